// ==== src/ahbRam_consts.svh ====
// Build-time constants shared by the AHB-Lite RAM slave and its testbench
// XLEN must be 32 or 64 and sets both the bus width and the RAM word width
// RAM_WORDS must be a power of two
// RAM_BASE must be aligned to the full RAM size in bytes

`ifndef AHBRAM_CONSTS_SVH
`define AHBRAM_CONSTS_SVH

// Data bus and storage word width in bits
`define XLEN 32

// Depth of the storage in XLEN words
`define RAM_WORDS 256

// First byte address decoded by the slave
`define RAM_BASE 32'h8000_0000

// Derived sizes that split a byte address into word offset and word index
`define RAM_BYTES (`RAM_WORDS * (`XLEN / 8))
`define WORD_OFF_BITS $clog2(`XLEN / 8)
`define RAM_IDX_BITS $clog2(`RAM_WORDS)

`endif

// ==== src/ahbRamPkg.sv ====
// Shared AHB-Lite encodings and the RAM word index type
// Encodings follow the AHB-Lite specification bit for bit
// Sizes above a doubleword have no name and are treated as oversize

`include "ahbRam_consts.svh"

package ahbRamPkg;

  ////////////////////////////////////////////////////////////////////////////
  // Bus encodings
  ////////////////////////////////////////////////////////////////////////////

  // HSIZE, the number of bytes moved is two to the power of the code
  typedef enum logic [2:0] {
    sizeByte   = 3'b000,
    sizeHalf   = 3'b001,
    sizeWord   = 3'b010,
    sizeDouble = 3'b011
  } hSizeT;

  // HTRANS, only nonseq and seq start a data phase
  typedef enum logic [1:0] {
    transIdle   = 2'b00,
    transBusy   = 2'b01,
    transNonseq = 2'b10,
    transSeq    = 2'b11
  } hTransT;

  // HRESP for AHB-Lite is a single bit
  typedef enum logic {
    respOkay  = 1'b0,
    respError = 1'b1
  } hRespT;

  ////////////////////////////////////////////////////////////////////////////
  // Storage addressing
  ////////////////////////////////////////////////////////////////////////////

  // Word index into the storage array
  typedef logic [`RAM_IDX_BITS-1:0] ramIdxT;

endpackage

// ==== src/ahbAddrDecode.sv ====
// Address phase capture for the AHB-Lite RAM slave
// Bursts are not tracked, a seq transfer is decoded like a nonseq one
// The captured phase is held for as long as the slave drives hReadyOut low
// Range, alignment and size errors are all folded into the single dErr flag

`timescale 1ns/10ps

`include "ahbRam_consts.svh"

module ahbAddrDecode import ahbRamPkg::*; (
  input  logic        HCLK,
  input  logic        rst,
  input  logic        hSel,
  input  logic [31:0] hAddr,
  input  hTransT      hTrans,
  input  logic        hWrite,
  input  hSizeT       hSize,
  input  logic        hReady,
  input  logic        hReadyOut,
  output logic        dValid,
  output logic        dWrite,
  output logic [31:0] dAddr,
  output hSizeT       dSize,
  output logic        dErr
);

  // Largest transfer that fits in one bus word
  localparam hSizeT maxSize = (`XLEN == 64) ? sizeDouble : sizeWord;

  logic        addrAccept;
  logic [31:0] byteOffset;
  logic        inRange;
  logic        aligned;
  logic        sizeOk;

  // A transfer starts only when selected, active and not held off by the bus
  assign addrAccept = hSel && hReady && (hTrans == transNonseq || hTrans == transSeq);

  // Addresses below the base wrap to a large offset and so fail the range test
  assign byteOffset = hAddr - `RAM_BASE;
  assign inRange    = byteOffset < 32'(`RAM_BYTES);
  assign sizeOk     = hSize <= maxSize;

  // The low address bits below the transfer size must all be zero
  always_comb begin
    case (hSize)
      sizeByte:   aligned = 1'b1;
      sizeHalf:   aligned = (hAddr[0] == 1'b0);
      sizeWord:   aligned = (hAddr[1:0] == 2'b00);
      sizeDouble: aligned = (hAddr[2:0] == 3'b000);
      default:    aligned = 1'b0;
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // Data phase registers
  ////////////////////////////////////////////////////////////////////////////

  // A stalled data phase keeps its flag until the slave releases the bus
  always_ff @(posedge HCLK) begin
    if (rst) begin
      dValid <= 1'b0;
    end else if (hReadyOut) begin
      dValid <= addrAccept;
    end
  end

  always_ff @(posedge HCLK) begin
    if (hReadyOut && addrAccept) begin
      dWrite <= hWrite;
      dAddr  <= hAddr;
      dSize  <= hSize;
      dErr   <= !(inRange && aligned && sizeOk);
    end
  end

  // A slave stall must also hold off the bus, or the next transfer would be lost
  assert property (@(posedge HCLK) disable iff (rst)
    !hReadyOut |-> !addrAccept);

endmodule

// ==== src/swByteMask.sv ====
// Store byte lane mask for the data phase of a write
// Only XLEN of 32 or 64 is built
// Misaligned or oversize codes still give a mask, the decode stage blocks them

`timescale 1ns/10ps

`include "ahbRam_consts.svh"

module swByteMask import ahbRamPkg::*; (
  input  hSizeT              dSize,
  input  logic [31:0]        dAddr,
  output logic [`XLEN/8-1:0] byteMask
);

  if (`XLEN == 64) begin : gen64
    // Eight lanes, the low three address bits pick the lanes
    always_comb begin
      case (dSize)
        sizeByte: byteMask = 8'b0000_0001 << dAddr[2:0];
        // A halfword starts on an even lane
        sizeHalf: byteMask = 8'b0000_0011 << {dAddr[2:1], 1'b0};
        sizeWord: begin
          if (dAddr[2]) begin
            byteMask = 8'b1111_0000;
          end else begin
            byteMask = 8'b0000_1111;
          end
        end
        default: byteMask = 8'b1111_1111;
      endcase
    end
  end else begin : gen32
    // Four lanes, a word or anything wider fills the bus
    always_comb begin
      case (dSize)
        sizeByte: byteMask = 4'b0001 << dAddr[1:0];
        sizeHalf: begin
          if (dAddr[1]) begin
            byteMask = 4'b1100;
          end else begin
            byteMask = 4'b0011;
          end
        end
        default: byteMask = 4'b1111;
      endcase
    end
  end

endmodule

// ==== src/ramArray.sv ====
// Byte-lane writable storage of RAM_WORDS words of XLEN bits
// Contents are not cleared by reset and start undefined in hardware
// A read and a write to the same word on one edge return the old word

`timescale 1ns/10ps

`include "ahbRam_consts.svh"

module ramArray import ahbRamPkg::*; (
  input  logic               HCLK,
  input  logic               writeEn,
  input  ramIdxT             writeIdx,
  input  logic [`XLEN/8-1:0] byteMask,
  input  logic [`XLEN-1:0]   hWData,
  input  logic               readEn,
  input  ramIdxT             readIdx,
  output logic [`XLEN-1:0]   hRData
);

  logic [`XLEN-1:0] mem [`RAM_WORDS];

  ////////////////////////////////////////////////////////////////////////////
  // Write port
  ////////////////////////////////////////////////////////////////////////////

  // Each lane is enabled on its own so narrow stores keep their neighbours
  always_ff @(posedge HCLK) begin
    if (writeEn) begin
      for (int lane = 0; lane < `XLEN / 8; lane++) begin
        if (byteMask[lane]) begin
          mem[writeIdx][lane*8 +: 8] <= hWData[lane*8 +: 8];
        end
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Read port
  ////////////////////////////////////////////////////////////////////////////

  // Registered read so the word appears during the data phase of the read
  // The register keeps its value between reads which lets the bus sample it
  // late in a stalled phase
  always_ff @(posedge HCLK) begin
    if (readEn) begin
      hRData <= mem[readIdx];
    end
  end

  // A write strobe with no lanes means the decode and mask stages disagree
  assert property (@(posedge HCLK) writeEn |-> byteMask != '0);

endmodule

// ==== src/ahbRamResponse.sv ====
// Ready and response sequencing for the AHB-Lite RAM slave
// Only two stalls exist, the first cycle of an error and one read-after-write wait
// A read that follows a write to the same word is replayed from storage
// The master is expected to drop its next transfer in the second error cycle

`timescale 1ns/10ps

`include "ahbRam_consts.svh"

module ahbRamResponse import ahbRamPkg::*; (
  input  logic        HCLK,
  input  logic        rst,
  input  logic        dValid,
  input  logic        dWrite,
  input  logic        dErr,
  input  logic [31:0] dAddr,
  input  logic        hSel,
  input  hTransT      hTrans,
  input  logic        hWrite,
  input  logic [31:0] hAddr,
  input  logic        hReady,
  output logic        hReadyOut,
  output hRespT       hResp,
  output logic        readEn,
  output ramIdxT      readIdx,
  output logic        writeEn,
  output ramIdxT      writeIdx
);

  logic   addrAccept;
  logic   errFirst;
  logic   errSecond;
  logic   rawStall;
  ramIdxT hIdx;
  ramIdxT dIdx;

  assign hIdx = hAddr[`WORD_OFF_BITS +: `RAM_IDX_BITS];
  assign dIdx = dAddr[`WORD_OFF_BITS +: `RAM_IDX_BITS];

  assign addrAccept = hSel && hReady && (hTrans == transNonseq || hTrans == transSeq);

  // Writes never wait, so the strobe lasts the whole single-cycle data phase
  assign writeEn  = dValid && dWrite && !dErr;
  assign writeIdx = dIdx;

  // In a replay cycle the held data-phase address drives the read port
  assign readEn  = rawStall || (addrAccept && !hWrite);
  assign readIdx = rawStall ? dIdx : hIdx;

  ////////////////////////////////////////////////////////////////////////////
  // Stall and error sequencing
  ////////////////////////////////////////////////////////////////////////////

  // The error holds the bus in its first cycle and releases it in the second
  assign errFirst  = dValid && dErr && !errSecond;
  assign hReadyOut = !errFirst && !rawStall;
  assign hResp     = (dValid && dErr) ? respError : respOkay;

  always_ff @(posedge HCLK) begin
    if (rst) begin
      errSecond <= 1'b0;
      rawStall  <= 1'b0;
    end else begin
      errSecond <= errFirst;
      // The read sampled on this edge saw the word before the write landed
      rawStall  <= addrAccept && !hWrite && writeEn && (hIdx == dIdx);
    end
  end

  // Neither stall source can hold the bus for two cycles running
  assert property (@(posedge HCLK) disable iff (rst) !hReadyOut |=> hReadyOut);

endmodule

// ==== src/ahbRam.sv ====
// AHB-Lite on-chip RAM slave, top level
// Single transfers only, HBURST, HPROT and HMASTLOCK are not connected
// hReady must be the combined bus ready and includes this slave's hReadyOut
// Reads always return the whole aligned XLEN word

`timescale 1ns/10ps

`include "ahbRam_consts.svh"

module ahbRam import ahbRamPkg::*; (
  input  logic             HCLK,
  input  logic             rst,
  input  logic             hSel,
  input  logic [31:0]      hAddr,
  input  hTransT           hTrans,
  input  logic             hWrite,
  input  hSizeT            hSize,
  input  logic [`XLEN-1:0] hWData,
  input  logic             hReady,
  output logic             hReadyOut,
  output hRespT            hResp,
  output logic [`XLEN-1:0] hRData
);

  // Data phase view of the accepted transfer
  logic               dValid;
  logic               dWrite;
  logic [31:0]        dAddr;
  hSizeT              dSize;
  logic               dErr;

  // Storage strobes
  logic [`XLEN/8-1:0] byteMask;
  logic               writeEn;
  ramIdxT             writeIdx;
  logic               readEn;
  ramIdxT             readIdx;

  ////////////////////////////////////////////////////////////////////////////
  // Decode, execute and result stages
  ////////////////////////////////////////////////////////////////////////////

  ahbAddrDecode decode0 (
    .HCLK, .rst, .hSel, .hAddr, .hTrans, .hWrite, .hSize, .hReady, .hReadyOut,
    .dValid, .dWrite, .dAddr, .dSize, .dErr
  );

  // Lanes come from the held data-phase size and address
  swByteMask mask0 (.dSize, .dAddr, .byteMask);

  ramArray ram0 (
    .HCLK, .writeEn, .writeIdx, .byteMask, .hWData, .readEn, .readIdx, .hRData
  );

  ahbRamResponse resp0 (
    .HCLK, .rst, .dValid, .dWrite, .dErr, .dAddr,
    .hSel, .hTrans, .hWrite, .hAddr, .hReady,
    .hReadyOut, .hResp, .readEn, .readIdx, .writeEn, .writeIdx
  );

endmodule

// ==== test/clockGen.sv ====
// Clock and reset source for the testbench
// HCLK has a 100 ns period and starts low
// rst is high for the first two rising edges and drops on a falling edge

`timescale 1ns/10ps

module clockGen (
  output logic HCLK,
  output logic rst
);

  initial begin
    HCLK = 1'b0;
    forever #50 HCLK = ~HCLK;
  end

  // Released away from the rising edge so the DUT sees a clean level
  initial begin
    rst = 1'b1;
    repeat (2) @(posedge HCLK);
    @(negedge HCLK);
    rst = 1'b0;
  end

endmodule

// ==== test/ahbRamTb.sv ====
// Testbench for the AHB-Lite RAM slave with one master and no other slaves
// hReady is looped from hReadyOut, inputs change on the falling edge
// Storage starts undefined, so every word is written over the bus before use
// Random stimulus comes from $random with one fixed seed

`timescale 1ns/10ps

`include "ahbRam_consts.svh"

module ahbRamTb import ahbRamPkg::*; ();

  typedef logic [`XLEN-1:0] xwordT;

  // One accepted transfer as the checker expects it to complete
  typedef struct {
    logic  isWrite;
    logic  expErr;
    xwordT expData;
    int    expWaits;
    time   acceptAt;
  } expectT;

  localparam int maxCode = $clog2(`XLEN / 8);
  localparam hSizeT fullSize = hSizeT'(3'(maxCode));
  localparam hSizeT oversize = (`XLEN == 64) ? hSizeT'(3'b100) : sizeDouble;
  localparam int waitLimit = 8;

  logic        HCLK;
  logic        rst;
  logic        hSel;
  logic [31:0] hAddr;
  hTransT      hTrans;
  logic        hWrite;
  hSizeT       hSize;
  xwordT       hWData;
  logic        hReady;
  logic        hReadyOut;
  hRespT       hResp;
  xwordT       hRData;

  xwordT  modelMem [`RAM_WORDS];
  expectT expQ[$];
  integer seed;
  int     errors;
  int     checks;
  int     tests;
  int     testsPassed;
  logic   aborted;

  // Transfer put on the address bus at the last falling edge
  logic   pendIssued;
  logic   pendWrite;
  xwordT  pendData;
  // A good write issued just before is what makes a read wait
  logic   lastWriteOk;
  ramIdxT lastWriteIdx;

  clockGen clk0 (.HCLK, .rst);

  assign hReady = hReadyOut;

  ahbRam dut0 (
    .HCLK, .rst, .hSel, .hAddr, .hTrans, .hWrite, .hSize, .hWData, .hReady,
    .hReadyOut, .hResp, .hRData
  );

  ////////////////////////////////////////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////////////////////////////////////////

  // Lanes from the first addressed byte up to the transfer's byte count
  function automatic logic [`XLEN/8-1:0] refMask(input logic [31:0] addr, input hSizeT size);
    logic [`XLEN/8-1:0] m;
    int first;
    int count;
    first = int'(addr % 32'(`XLEN / 8));
    count = 1 << int'(size);
    m = '0;
    for (int lane = 0; lane < `XLEN / 8; lane++) begin
      if (lane >= first && lane < first + count) begin
        m[lane] = 1'b1;
      end
    end
    return m;
  endfunction

  // Oversize, outside the RAM window, or not aligned to its own size
  function automatic logic refErr(input logic [31:0] addr, input hSizeT size);
    logic [31:0] nBytes;
    if (int'(size) > maxCode) begin
      return 1'b1;
    end
    if (addr < `RAM_BASE || addr >= `RAM_BASE + 32'(`RAM_BYTES)) begin
      return 1'b1;
    end
    nBytes = 32'd1 << size;
    return (addr & (nBytes - 32'd1)) != 32'd0;
  endfunction

  function automatic ramIdxT wordIndex(input logic [31:0] addr);
    return addr[`WORD_OFF_BITS +: `RAM_IDX_BITS];
  endfunction

  function automatic logic [31:0] wordAddr(input ramIdxT idx);
    return `RAM_BASE + (32'(idx) << `WORD_OFF_BITS);
  endfunction

  // Every 32-bit slice mixes the full byte address
  function automatic xwordT fillWord(input logic [31:0] addr);
    xwordT v;
    for (int i = 0; i < `XLEN / 32; i++) begin
      v[i*32 +: 32] = addr ^ (32'h9e37_79b9 * 32'(i + 1));
    end
    return v;
  endfunction

  function automatic int randBelow(input int n);
    int r;
    r = $random(seed);
    return (r & 32'h7fff_ffff) % n;
  endfunction

  function automatic xwordT randWord();
    xwordT v;
    for (int i = 0; i < `XLEN / 32; i++) begin
      v[i*32 +: 32] = $random(seed);
    end
    return v;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Compare tasks and reporting
  ////////////////////////////////////////////////////////////////////////////

  task automatic checkData(input string name, input xwordT got, input xwordT exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("mismatch at time %0t: %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic checkResp(input string name, input hRespT got, input hRespT exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("mismatch at time %0t: %s got %b expected %b", $time, name, got, exp);
    end
  endtask

  task automatic checkFlag(input string name, input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("mismatch at time %0t: %s got %b expected %b", $time, name, got, exp);
    end
  endtask

  task automatic checkCount(input string name, input int got, input int exp);
    checks++;
    if (got != exp) begin
      errors++;
      $display("mismatch at time %0t: %s got %0d expected %0d", $time, name, got, exp);
    end
  endtask

  task automatic endRun();
    $display("tests %0d, passed %0d, checks %0d, mismatches %0d",
             tests, testsPassed, checks, errors);
    if (errors == 0 && !aborted) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  endtask

  task automatic abortRun(input string why);
    $display("timeout at time %0t: %s", $time, why);
    aborted = 1'b1;
    endRun();
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Bus master
  ////////////////////////////////////////////////////////////////////////////

  // The transfer driven one edge ago was accepted and now owns the data bus
  task automatic nextEdge();
    @(negedge HCLK);
    if (pendIssued && pendWrite) begin
      hWData = pendData;
    end
    pendIssued = 1'b0;
  endtask

  task automatic driveIdle();
    hSel = 1'b0;
    hTrans = transIdle;
    lastWriteOk = 1'b0;
  endtask

  task automatic idleCycles(input int n);
    repeat (n) begin
      nextEdge();
      driveIdle();
    end
  endtask

  task automatic issue(input logic wr, input logic [31:0] addr, input hSizeT size,
                       input xwordT data);
    expectT e;
    ramIdxT idx;
    logic [`XLEN/8-1:0] mask;
    int guard;
    guard = 0;
    nextEdge();
    // Held off through stalls and through the second cycle of an error
    while (!(hReadyOut === 1'b1 && hResp === respOkay)) begin
      driveIdle();
      guard++;
      if (guard > waitLimit) begin
        abortRun("bus stayed busy and the transfer could not be issued");
      end
      nextEdge();
    end
    idx = wordIndex(addr);
    mask = refMask(addr, size);
    e.isWrite = wr;
    e.expErr = refErr(addr, size);
    e.expData = '0;
    e.expWaits = e.expErr ? 1 : 0;
    // Accepted on the rising edge half a period from now
    e.acceptAt = $time + 64'd50;
    if (!e.expErr && wr) begin
      for (int lane = 0; lane < `XLEN / 8; lane++) begin
        if (mask[lane]) begin
          modelMem[idx][lane*8 +: 8] = data[lane*8 +: 8];
        end
      end
    end else if (!e.expErr) begin
      e.expData = modelMem[idx];
      if (lastWriteOk && lastWriteIdx == idx) begin
        e.expWaits = 1;
      end
    end
    expQ.push_back(e);
    hSel = 1'b1;
    hTrans = transNonseq;
    hAddr = addr;
    hWrite = wr;
    hSize = size;
    pendIssued = 1'b1;
    pendWrite = wr;
    pendData = data;
    lastWriteOk = wr && !e.expErr;
    lastWriteIdx = idx;
  endtask

  task automatic errorCase(input logic [31:0] addr, input hSizeT size);
    issue(1'b1, addr, size, randWord());
    // The word a broken decode would have hit must be unchanged
    issue(1'b0, wordAddr(wordIndex(addr)), fullSize, '0);
  endtask

  task automatic finishTest(input string name, input int errBefore);
    int guard;
    guard = 0;
    while (expQ.size() > 0) begin
      idleCycles(1);
      guard++;
      if (guard > waitLimit) begin
        abortRun("outstanding transfers never completed");
      end
    end
    tests++;
    if (errors == errBefore) begin
      testsPassed++;
      $display("test %0d %s: ok", tests, name);
    end else begin
      $display("test %0d %s: failed with %0d mismatches", tests, name, errors - errBefore);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Checker, one sample per falling edge
  ////////////////////////////////////////////////////////////////////////////

  initial begin : checkProc
    expectT head;
    int waits;
    waits = 0;
    forever begin
      @(negedge HCLK);
      if (expQ.size() > 0 && expQ[0].acceptAt < $time) begin
        head = expQ[0];
        if (hReadyOut !== 1'b1) begin
          waits++;
          if (head.expErr) begin
            checkResp("hResp", hResp, respError);
          end
          if (waits > waitLimit) begin
            abortRun("data phase never completed");
          end
        end else begin
          checkResp("hResp", hResp, head.expErr ? respError : respOkay);
          checkCount("wait states", waits, head.expWaits);
          if (!head.isWrite && !head.expErr) begin
            checkData("hRData", hRData, head.expData);
          end
          void'(expQ.pop_front());
          waits = 0;
        end
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin : mainProc
    int errBefore;
    int guard;
    int slot;
    int s;
    ramIdxT idx;
    logic [31:0] a;
    seed = 32'h882a76be;
    errors = 0;
    checks = 0;
    tests = 0;
    testsPassed = 0;
    aborted = 1'b0;
    hSel = 1'b0;
    hAddr = '0;
    hTrans = transIdle;
    hWrite = 1'b0;
    hSize = sizeByte;
    hWData = '0;
    pendIssued = 1'b0;
    pendWrite = 1'b0;
    pendData = '0;
    lastWriteOk = 1'b0;
    lastWriteIdx = '0;
    foreach (modelMem[i]) begin
      modelMem[i] = '0;
    end
    guard = 0;
    while (rst !== 1'b0) begin
      @(posedge HCLK);
      guard++;
      if (guard > 10) begin
        abortRun("reset was never released");
      end
    end
    nextEdge();
    errBefore = errors;
    checkFlag("hReadyOut", hReadyOut, 1'b1);
    checkResp("hResp", hResp, respOkay);
    finishTest("reset state", errBefore);

    errBefore = errors;
    for (int i = 0; i < `RAM_WORDS; i++) begin
      a = wordAddr(ramIdxT'(i));
      issue(1'b1, a, fullSize, fillWord(a));
    end
    for (int i = 0; i < `RAM_WORDS; i++) begin
      issue(1'b0, wordAddr(ramIdxT'(i)), fullSize, '0);
    end
    finishTest("fill and read back", errBefore);

    // Every size at every legal offset, each in a word of its own
    errBefore = errors;
    slot = 16;
    for (int sz = 0; sz <= maxCode; sz++) begin
      for (int off = 0; off < `XLEN / 8; off += (1 << sz)) begin
        a = wordAddr(ramIdxT'(slot));
        issue(1'b1, a + 32'(off), hSizeT'(3'(sz)), randWord());
        idleCycles(1);
        issue(1'b0, a, fullSize, '0);
        slot++;
      end
    end
    finishTest("byte lanes", errBefore);

    errBefore = errors;
    for (int n = 0; n < 300; n++) begin
      s = randBelow(maxCode + 1);
      idx = ramIdxT'(randBelow(`RAM_WORDS));
      a = wordAddr(idx) + 32'(randBelow((`XLEN / 8) >> s) << s);
      idleCycles(randBelow(4));
      issue(randBelow(2) == 1, a, hSizeT'(3'(s)), randWord());
    end
    finishTest("random traffic", errBefore);

    // Read issued in the write's data phase, alternating full and half writes
    errBefore = errors;
    for (int k = 0; k < 4; k++) begin
      a = wordAddr(ramIdxT'(100 + k));
      idleCycles(1);
      issue(1'b1, a + 32'((k % 2) * 2), (k % 2 == 1) ? sizeHalf : fullSize, randWord());
      issue(1'b0, a, fullSize, '0);
    end
    finishTest("read after write", errBefore);

    errBefore = errors;
    errorCase(`RAM_BASE + 32'(`RAM_BYTES) + 32'd8, sizeByte);
    errorCase(`RAM_BASE - 32'(`XLEN / 8), fullSize);
    errorCase(`RAM_BASE + 32'd65, sizeHalf);
    errorCase(`RAM_BASE + 32'd66, sizeWord);
    errorCase(`RAM_BASE + 32'd64, oversize);
    issue(1'b0, `RAM_BASE + 32'(`RAM_BYTES), sizeWord, '0);
    finishTest("error responses", errBefore);

    endRun();
  end

endmodule

// ==== ahbRam.f ====
+incdir+src
src/ahbRamPkg.sv
src/ahbAddrDecode.sv
src/swByteMask.sv
src/ramArray.sv
src/ahbRamResponse.sv
src/ahbRam.sv
test/clockGen.sv
test/ahbRamTb.sv

// ==== runSim.sh ====
#!/bin/sh
# Builds the AHB-Lite RAM testbench with Verilator 5 and runs it.
# The exit status is zero only when the simulation log holds the pass line.

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
SIM_BIN=simAhbRam
SIM_LOG=sim.log

verilator --binary --timing --assert \
  -f ahbRam.f --top-module ahbRamTb -Mdir "$BUILD_DIR" -o "$SIM_BIN"
status=$?
if [ "$status" -ne 0 ]; then
  echo "verilator build failed with status $status"
  exit "$status"
fi

"./$BUILD_DIR/$SIM_BIN" > "$SIM_LOG" 2>&1
status=$?
cat "$SIM_LOG"
if [ "$status" -ne 0 ]; then
  echo "simulation exited with status $status"
  exit "$status"
fi

if grep -qF "*** TEST PASSED ***" "$SIM_LOG"; then
  echo "simulation passed"
  exit 0
else
  echo "simulation failed, see $SIM_LOG"
  exit 1
fi
